// ==== bench/bpu_tb.sv ====
`default_nettype none

module bpu_tb import bpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD   = 40;
    localparam int HALF     = PERIOD / 2;
    localparam int NUM_ROWS = 22;
    localparam int TIMEOUT  = (NUM_ROWS + 20) * PERIOD;

    // addresses used by the directed rows
    localparam addr_t P_PC  = 32'h0000_1000;   // conditional branch
    localparam addr_t T_TGT = 32'h0000_1800;   // its trained target
    localparam int    BOFF  = 32'h40;          // offset coded in the branch
    localparam addr_t Q_PC  = 32'h0000_2000;   // jal
    localparam int    JOFF  = -256;
    localparam addr_t U_TGT = 32'h0000_8880;
    localparam addr_t R_PC  = 32'h0000_3100;   // return
    localparam addr_t A_RA  = 32'h0000_4004;
    localparam addr_t B_RA  = 32'h0000_5008;
    localparam addr_t C_RA  = 32'h0000_6000;

    localparam addr_t NOP = 32'h0000_0013;     // addi x0, x0, 0
    localparam addr_t RET = 32'h0000_8067;     // jalr x0, 0(ra)

    typedef struct packed {
        addr_t      pc;
        addr_t      inst;
        logic       fb_valid;
        logic       fb_taken;
        addr_t      fb_pc;
        addr_t      fb_target;
        logic       fb_ret;
        logic [7:0] fb_src;     // row whose prediction is being resolved
        logic       push;
        addr_t      push_addr;
        logic       stall;
        logic       exp_cf;
        logic       exp_taken;
        addr_t      exp_next;
        logic       chk_prov;
        provider_t  exp_prov;
    } row_t;

    logic       clk;
    logic       rst;
    addr_t      if_pc;
    addr_t      if_inst;
    ex_update_t ex_upd;
    logic       id_push;
    addr_t      id_push_addr;
    logic       ex_stall;
    pred_t      pred;

    row_t  rows [0:NUM_ROWS-1];
    pred_t seen [0:NUM_ROWS-1];
    hist_t exp_hist;
    int unsigned seed;
    int unsigned discard;

    bpu_top #(
        .BIMODAL_ENTRIES (512),
        .TAGE_ENTRIES    (256),
        .BTB_ENTRIES     (256),
        .RAS_DEPTH       (32)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .if_pc_i        (if_pc),
        .if_inst_i      (if_inst),
        .ex_upd_i       (ex_upd),
        .id_push_i      (id_push),
        .id_push_addr_i (id_push_addr),
        .ex_stall_i     (ex_stall),
        .pred_o         (pred)
    );

    always #HALF clk = ~clk;

    // beq x1, x2 with the given byte offset
    function automatic addr_t encode_branch(int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], OP_BRANCH};
    endfunction

    function automatic addr_t encode_jal(int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, OP_JAL};   // rd x0
    endfunction

    function automatic row_t fetch_row(addr_t pc, addr_t inst, logic cf, logic tk, addr_t nxt);
        row_t r;
        r = '0;
        r.pc        = pc;
        r.inst      = inst;
        r.exp_cf    = cf;
        r.exp_taken = tk;
        r.exp_next  = nxt;
        return r;
    endfunction

    // non-control instruction at a random word address
    function automatic row_t random_row();
        addr_t pc;
        pc = $urandom & 32'hFFFF_FFFC;
        return fetch_row(pc, NOP, 1'b0, 1'b0, pc + 32'd4);
    endfunction

    function automatic row_t with_update(row_t r, logic tk, addr_t pc, addr_t tgt,
                                         logic ret, int src);
        r.fb_valid  = 1'b1;
        r.fb_taken  = tk;
        r.fb_pc     = pc;
        r.fb_target = tgt;
        r.fb_ret    = ret;
        r.fb_src    = src[7:0];
        return r;
    endfunction

    function automatic row_t with_push(row_t r, addr_t addr, logic stall);
        r.push      = 1'b1;
        r.push_addr = addr;
        r.stall     = stall;
        return r;
    endfunction

    function automatic row_t with_provider(row_t r, provider_t p);
        r.chk_prov = 1'b1;
        r.exp_prov = p;
        return r;
    endfunction

    task automatic build_table();
        addr_t br;
        addr_t jal;
        br  = encode_branch(BOFF);
        jal = encode_jal(JOFF);
        for (int i = 0; i < 4; i++) begin
            rows[i] = random_row();
        end
        // cold tables
        rows[4] = fetch_row(P_PC, br, 1'b1, 1'b0, P_PC + 32'd4);
        rows[5] = fetch_row(Q_PC, jal, 1'b1, 1'b1, Q_PC + addr_t'(JOFF));
        // taken misprediction of P, seen only from the next row on
        rows[6] = with_update(fetch_row(P_PC, br, 1'b1, 1'b0, P_PC + 32'd4),
                              1'b1, P_PC, T_TGT, 1'b0, 4);
        rows[7] = fetch_row(P_PC, br, 1'b1, 1'b1, T_TGT);
        // three not-taken outcomes of P
        rows[8] = with_update(fetch_row(P_PC, br, 1'b1, 1'b1, T_TGT),
                              1'b0, P_PC, P_PC + 32'd4, 1'b0, 7);
        rows[9] = with_update(fetch_row(P_PC, br, 1'b1, 1'b0, P_PC + 32'd4),
                              1'b0, P_PC, P_PC + 32'd4, 1'b0, 8);
        rows[10] = with_update(fetch_row(P_PC, br, 1'b1, 1'b0, P_PC + 32'd4),
                               1'b0, P_PC, P_PC + 32'd4, 1'b0, 9);
        rows[11] = fetch_row(P_PC, br, 1'b1, 1'b0, P_PC + 32'd4);
        // return stack
        rows[12] = with_push(fetch_row(R_PC, RET, 1'b1, 1'b0, R_PC + 32'd4), A_RA, 1'b0);
        rows[13] = with_push(fetch_row(R_PC, RET, 1'b1, 1'b1, A_RA), B_RA, 1'b0);
        rows[14] = with_push(fetch_row(R_PC, RET, 1'b1, 1'b1, B_RA), C_RA, 1'b1);
        rows[15] = with_update(fetch_row(R_PC, RET, 1'b1, 1'b1, B_RA),
                               1'b1, R_PC, B_RA, 1'b1, 14);
        rows[16] = with_update(fetch_row(R_PC, RET, 1'b1, 1'b1, A_RA),
                               1'b1, R_PC, A_RA, 1'b1, 15);
        rows[17] = fetch_row(R_PC, RET, 1'b1, 1'b0, R_PC + 32'd4);
        // jal retargeted through the btb
        rows[18] = with_update(fetch_row(Q_PC, jal, 1'b1, 1'b1, Q_PC + addr_t'(JOFF)),
                               1'b1, Q_PC, U_TGT, 1'b0, 5);
        rows[19] = fetch_row(Q_PC, jal, 1'b1, 1'b1, U_TGT);
        rows[20] = random_row();
        rows[21] = random_row();
        // no tagged entry exists before the misprediction of row 6
        for (int i = 0; i <= 6; i++) begin
            rows[i] = with_provider(rows[i], PROV_BIM);
        end
        // P is allocated into T1 and stays there
        for (int i = 7; i <= 11; i++) begin
            rows[i] = with_provider(rows[i], PROV_T1);
        end
    endtask

    task automatic apply_row(row_t r);
        pred_t src;
        if_pc        = r.pc;
        if_inst      = r.inst;
        id_push      = r.push;
        id_push_addr = r.push_addr;
        ex_stall     = r.stall;
        ex_upd       = '0;
        if (r.fb_valid) begin
            src = seen[r.fb_src];
            ex_upd.valid    = 1'b1;
            ex_upd.taken    = r.fb_taken;
            ex_upd.pdt_true = (src.taken == r.fb_taken);   // execute compares outcome
            ex_upd.pc       = r.fb_pc;
            ex_upd.target   = r.fb_target;
            ex_upd.history  = src.history;
            ex_upd.provider = src.provider;
            ex_upd.is_ret   = r.fb_ret;
        end
    endtask

    task automatic compare_addr(addr_t got, addr_t exp, int row, string what);
        if (got !== exp) begin
            $display("Something failed");
            $display("mismatch at %0t: row %0d %s is %h, expected %h",
                     $time, row, what, got, exp);
            $fatal(1, "first error, run stopped");
        end
    endtask

    task automatic compare_flag(logic got, logic exp, int row, string what);
        if (got !== exp) begin
            $display("Something failed");
            $display("mismatch at %0t: row %0d %s is %b, expected %b",
                     $time, row, what, got, exp);
            $fatal(1, "first error, run stopped");
        end
    endtask

    task automatic compare_hist(hist_t got, hist_t exp, int row, string what);
        if (got !== exp) begin
            $display("Something failed");
            $display("mismatch at %0t: row %0d %s is %h, expected %h",
                     $time, row, what, got, exp);
            $fatal(1, "first error, run stopped");
        end
    endtask

    task automatic compare_provider(provider_t got, provider_t exp, int row, string what);
        if (got !== exp) begin
            $display("Something failed");
            $display("mismatch at %0t: row %0d %s is %0d, expected %0d",
                     $time, row, what, got, exp);
            $fatal(1, "first error, run stopped");
        end
    endtask

    initial begin
        #TIMEOUT;
        $display("Something failed");
        $display("timeout: the table did not finish within %0d ns", TIMEOUT);
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        if_pc        = '0;
        if_inst      = '0;
        ex_upd       = '0;
        id_push      = 1'b0;
        id_push_addr = '0;
        ex_stall     = 1'b0;
        exp_hist     = '0;
        seed         = 38;
        discard      = $urandom(seed);
        build_table();

        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk);
            apply_row(rows[i]);
            #(HALF - 1);   // just before the rising edge
            compare_flag(pred.is_cf, rows[i].exp_cf, i, "is_cf");
            compare_flag(pred.taken, rows[i].exp_taken, i, "taken");
            compare_addr(pred.next_pc, rows[i].exp_next, i, "next_pc");
            compare_hist(pred.history, exp_hist, i, "history");
            if (rows[i].chk_prov)
                compare_provider(pred.provider, rows[i].exp_prov, i, "provider");
            seen[i] = pred;
            // each resolved outcome shifts in at the edge ending the row
            if (rows[i].fb_valid)
                exp_hist = {exp_hist[HIST_W-2:0], rows[i].fb_taken};
        end

        @(negedge clk);
        ex_upd  = '0;
        id_push = 1'b0;
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/bpu_btb.sv ====
`default_nettype none

module bpu_btb import bpu_pkg::*; #(
    parameter int BTB_ENTRIES = 256
) (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      pc_i,
    input  ex_update_t upd_i,
    output logic       hit_o,
    output addr_t      target_o
);

    localparam int IDX_W  = $clog2(BTB_ENTRIES);
    localparam int BTAG_W = XLEN - IDX_W - 2;   // rest of the pc above the index

    logic [BTAG_W-1:0]      btb_tag    [0:BTB_ENTRIES-1];
    addr_t                  btb_target [0:BTB_ENTRIES-1];
    logic [BTB_ENTRIES-1:0] btb_valid;

    logic [IDX_W-1:0]  rd_idx;
    logic [BTAG_W-1:0] rd_tag;
    logic [IDX_W-1:0]  wr_idx;
    logic [BTAG_W-1:0] wr_tag;
    logic              wr_en;

    // lookup, word aligned
    assign rd_idx = pc_i[IDX_W+1:2];
    assign rd_tag = pc_i[XLEN-1:IDX_W+2];

    assign hit_o    = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);
    assign target_o = btb_target[rd_idx];

    // only taken control transfers are written
    assign wr_idx = upd_i.pc[IDX_W+1:2];
    assign wr_tag = upd_i.pc[XLEN-1:IDX_W+2];
    assign wr_en  = upd_i.valid && upd_i.taken;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btb_valid <= '0;
        end else if (wr_en) begin
            btb_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            btb_tag[wr_idx]    <= wr_tag;
            btb_target[wr_idx] <= upd_i.target;
        end
    end

endmodule

`default_nettype wire

// ==== source/bpu_decode.sv ====
`default_nettype none

module bpu_decode import bpu_pkg::*; (
    input  addr_t       inst_i,
    output inst_class_t class_o
);

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] imm_i;
    logic        jalr;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign imm_i  = inst_i[31:20];

    assign jalr = (opcode == OP_JALR);

    always_comb begin
        class_o.is_branch = (opcode == OP_BRANCH);
        class_o.is_jal    = (opcode == OP_JAL);
        class_o.is_jalr   = jalr;

        // ret is jalr x0, 0(ra) or jalr x0, 0(t0)
        class_o.is_ret = jalr && (rd == 5'd0) && (imm_i == 12'd0) &&
                         ((rs1 == 5'd1) || (rs1 == 5'd5));

        class_o.br_offset = {
            {20{inst_i[31]}},
            inst_i[7],
            inst_i[30:25],
            inst_i[11:8],
            1'b0
        };

        class_o.jal_offset = {
            {12{inst_i[31]}},
            inst_i[19:12],
            inst_i[20],
            inst_i[30:21],
            1'b0
        };
    end

endmodule

`default_nettype wire

// ==== source/bpu_direction.sv ====
`default_nettype none

module bpu_direction import bpu_pkg::*; #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGE_ENTRIES    = 256
) (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      pc_i,
    input  ex_update_t upd_i,
    output logic       taken_o,
    output provider_t  provider_o,
    output hist_t      history_o
);

    localparam int BM_IDX_W = $clog2(BIMODAL_ENTRIES);
    localparam int TG_IDX_W = $clog2(TAGE_ENTRIES);

    hist_t history;

    ctr_t bimodal [0:BIMODAL_ENTRIES-1];

    tag_t t0_tag [0:TAGE_ENTRIES-1];
    ctr_t t0_ctr [0:TAGE_ENTRIES-1];
    tag_t t1_tag [0:TAGE_ENTRIES-1];
    ctr_t t1_ctr [0:TAGE_ENTRIES-1];
    logic [TAGE_ENTRIES-1:0] t0_valid;
    logic [TAGE_ENTRIES-1:0] t1_valid;

    // index and tag hashes, shared by lookup and training
    function automatic logic [TG_IDX_W-1:0] t0_index(addr_t pc, hist_t h);
        return pc[TG_IDX_W-1:0] ^ h[TG_IDX_W-1:0];
    endfunction

    function automatic logic [TG_IDX_W-1:0] t1_index(addr_t pc, hist_t h);
        return pc[TG_IDX_W-1:0] ^ h[HIST_W-1 -: TG_IDX_W];
    endfunction

    function automatic tag_t t0_hash(addr_t pc, hist_t h);
        return pc[17:8] ^ h[HIST_W-1 -: TAG_W];    // older history bits
    endfunction

    function automatic tag_t t1_hash(addr_t pc, hist_t h);
        return pc[17:8] ^ tag_t'(h[7:0]);
    endfunction

    function automatic ctr_t ctr_step(ctr_t c, logic up);
        if (up)
            return (c == 2'b11) ? c : c + 2'd1;
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    // lookup
    logic [BM_IDX_W-1:0] bm_idx;
    logic [TG_IDX_W-1:0] t0_idx, t1_idx;
    tag_t                t0_tag_val, t1_tag_val;
    logic                t0_match, t1_match;

    assign bm_idx     = pc_i[BM_IDX_W:1];
    assign t0_idx     = t0_index(pc_i, history);
    assign t1_idx     = t1_index(pc_i, history);
    assign t0_tag_val = t0_hash(pc_i, history);
    assign t1_tag_val = t1_hash(pc_i, history);

    assign t0_match = t0_valid[t0_idx] &&
                      (t0_tag[t0_idx][TAG_W-1 -: PTAG_W] == t0_tag_val[TAG_W-1 -: PTAG_W]);
    assign t1_match = t1_valid[t1_idx] &&
                      (t1_tag[t1_idx][TAG_W-1 -: PTAG_W] == t1_tag_val[TAG_W-1 -: PTAG_W]);

    always_comb begin
        if (t1_match) begin
            provider_o = PROV_T1;
            taken_o    = t1_ctr[t1_idx][1];
        end else if (t0_match) begin
            provider_o = PROV_T0;
            taken_o    = t0_ctr[t0_idx][1];
        end else begin
            provider_o = PROV_BIM;
            taken_o    = bimodal[bm_idx][1];
        end
    end

    assign history_o = history;

    // training, indexed with the history returned from execute
    logic [BM_IDX_W-1:0] u_bm_idx;
    logic [TG_IDX_W-1:0] u_t0_idx, u_t1_idx;
    tag_t                u_t0_tag, u_t1_tag;
    logic                bim_miss, t1_present;
    logic                alloc_t0, alloc_t1, train_t0, train_t1;
    ctr_t                weak_ctr, t0_new_ctr, t1_new_ctr;

    assign u_bm_idx = upd_i.pc[BM_IDX_W:1];
    assign u_t0_idx = t0_index(upd_i.pc, upd_i.history);
    assign u_t1_idx = t1_index(upd_i.pc, upd_i.history);
    assign u_t0_tag = t0_hash(upd_i.pc, upd_i.history);
    assign u_t1_tag = t1_hash(upd_i.pc, upd_i.history);

    assign bim_miss   = upd_i.valid && !upd_i.pdt_true && (upd_i.provider == PROV_BIM);
    assign t1_present = t1_valid[u_t1_idx] && (t1_tag[u_t1_idx] == u_t1_tag);
    assign alloc_t1   = bim_miss && !t1_present;
    assign alloc_t0   = bim_miss && t1_present;   // T1 already holds it
    assign train_t0   = upd_i.valid && (upd_i.provider == PROV_T0);
    assign train_t1   = upd_i.valid && (upd_i.provider == PROV_T1);

    assign weak_ctr   = upd_i.taken ? 2'b10 : 2'b01;
    // strong reset on a wrong tagged prediction
    assign t0_new_ctr = upd_i.pdt_true ? ctr_step(t0_ctr[u_t0_idx], upd_i.taken)
                                       : {2{upd_i.taken}};
    assign t1_new_ctr = upd_i.pdt_true ? ctr_step(t1_ctr[u_t1_idx], upd_i.taken)
                                       : {2{upd_i.taken}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history <= '0;
            t0_valid <= '0;
            t1_valid <= '0;
            for (int i = 0; i < BIMODAL_ENTRIES; i++) begin
                bimodal[i] <= 2'b01;    // weakly not taken
            end
        end else if (upd_i.valid) begin
            history <= {history[HIST_W-2:0], upd_i.taken};
            bimodal[u_bm_idx] <= ctr_step(bimodal[u_bm_idx], upd_i.taken);
            if (alloc_t0)
                t0_valid[u_t0_idx] <= 1'b1;
            if (alloc_t1)
                t1_valid[u_t1_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_t0) begin
            t0_tag[u_t0_idx] <= u_t0_tag;
            t0_ctr[u_t0_idx] <= weak_ctr;
        end else if (train_t0) begin
            t0_ctr[u_t0_idx] <= t0_new_ctr;
        end
        if (alloc_t1) begin
            t1_tag[u_t1_idx] <= u_t1_tag;
            t1_ctr[u_t1_idx] <= weak_ctr;
        end else if (train_t1) begin
            t1_ctr[u_t1_idx] <= t1_new_ctr;
        end
    end

endmodule

`default_nettype wire

// ==== source/bpu_pkg.sv ====
`default_nettype none

package bpu_pkg;

    localparam int XLEN   = 32;
    localparam int HIST_W = 16;
    localparam int TAG_W  = 10;
    localparam int PTAG_W = 6;   // upper tag bits used for matching

    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [HIST_W-1:0] hist_t;
    typedef logic [1:0]        ctr_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [1:0]        provider_t;   // 0 bimodal, 1 T0, 2 T1

    localparam provider_t PROV_BIM = 2'd0;
    localparam provider_t PROV_T0  = 2'd1;
    localparam provider_t PROV_T1  = 2'd2;

    // RV32I opcodes of the control transfer instructions
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef struct packed {
        logic  is_branch;
        logic  is_jal;
        logic  is_jalr;
        logic  is_ret;
        addr_t br_offset;    // sign-extended B-type immediate
        addr_t jal_offset;   // sign-extended J-type immediate
    } inst_class_t;

    // feedback from execute, one strobe per resolved control instruction
    typedef struct packed {
        logic      valid;
        logic      taken;
        logic      pdt_true;
        addr_t     pc;
        addr_t     target;
        hist_t     history;    // history seen at prediction time
        provider_t provider;   // provider returned from pred_o
        logic      is_ret;
    } ex_update_t;

    typedef struct packed {
        logic      is_cf;
        logic      taken;
        addr_t     next_pc;
        provider_t provider;
        hist_t     history;
    } pred_t;

endpackage

`default_nettype wire

// ==== source/bpu_ras.sv ====
`default_nettype none

module bpu_ras import bpu_pkg::*; #(
    parameter int RAS_DEPTH = 32
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push_i,
    input  addr_t      push_addr_i,
    input  logic       stall_i,
    input  ex_update_t upd_i,
    output addr_t      top_o,
    output logic       valid_o
);

    localparam int IDX_W = $clog2(RAS_DEPTH);

    addr_t            stack [0:RAS_DEPTH-1];
    logic [IDX_W:0]   sp;        // number of live entries
    logic [IDX_W:0]   sp_pop;    // sp after a possible pop
    logic [IDX_W-1:0] top_idx;
    logic             do_pop, do_push;

    // a taken return resolved in execute leaves the stack
    assign do_pop = upd_i.valid && upd_i.taken && upd_i.is_ret && !stall_i && (sp != '0);

    // pop first, then push into the freed slot
    assign sp_pop  = do_pop ? sp - 1'b1 : sp;
    assign do_push = push_i && !stall_i && (sp_pop < RAS_DEPTH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= '0;
        end else if (do_pop || do_push) begin
            sp <= do_push ? sp_pop + 1'b1 : sp_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            stack[sp_pop[IDX_W-1:0]] <= push_addr_i;
    end

    assign top_idx = sp[IDX_W-1:0] - 1'b1;
    assign top_o   = stack[top_idx];   // meaningless when empty
    assign valid_o = (sp != '0);

endmodule

`default_nettype wire

// ==== source/bpu_result.sv ====
`default_nettype none

module bpu_result import bpu_pkg::*; (
    input  addr_t       pc_i,
    input  inst_class_t class_i,
    input  logic        dir_taken_i,
    input  provider_t   provider_i,
    input  hist_t       history_i,
    input  logic        btb_hit_i,
    input  addr_t       btb_target_i,
    input  addr_t       ras_top_i,
    input  logic        ras_valid_i,
    output pred_t       pred_o
);

    addr_t seq_pc;

    assign seq_pc = pc_i + 32'd4;

    always_comb begin
        pred_o.is_cf    = class_i.is_branch || class_i.is_jal || class_i.is_jalr;
        pred_o.taken    = 1'b0;
        pred_o.next_pc  = seq_pc;
        pred_o.provider = provider_i;
        pred_o.history  = history_i;

        if (class_i.is_ret) begin
            // empty stack falls back to sequential fetch
            if (ras_valid_i) begin
                pred_o.taken   = 1'b1;
                pred_o.next_pc = ras_top_i;
            end
        end else if (class_i.is_jal) begin
            pred_o.taken   = 1'b1;
            pred_o.next_pc = btb_hit_i ? btb_target_i : pc_i + class_i.jal_offset;
        end else if (class_i.is_branch || class_i.is_jalr) begin
            pred_o.taken = dir_taken_i;
            if (dir_taken_i) begin
                if (btb_hit_i)
                    pred_o.next_pc = btb_target_i;
                else if (class_i.is_branch)
                    pred_o.next_pc = pc_i + class_i.br_offset;
                // jalr without a btb entry has no known target
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/bpu_top.sv ====
`default_nettype none

module bpu_top import bpu_pkg::*; #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGE_ENTRIES    = 256,
    parameter int BTB_ENTRIES     = 256,
    parameter int RAS_DEPTH       = 32
) (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      if_pc_i,
    input  addr_t      if_inst_i,
    input  ex_update_t ex_upd_i,
    input  logic       id_push_i,      // call seen in decode
    input  addr_t      id_push_addr_i,
    input  logic       ex_stall_i,
    output pred_t      pred_o
);

    inst_class_t inst_class;
    logic        dir_taken;
    provider_t   provider;
    hist_t       history;
    logic        btb_hit;
    addr_t       btb_target;
    addr_t       ras_top;
    logic        ras_valid;

    bpu_decode u_decode (
        .inst_i  (if_inst_i),
        .class_o (inst_class)
    );

    bpu_direction #(
        .BIMODAL_ENTRIES (BIMODAL_ENTRIES),
        .TAGE_ENTRIES    (TAGE_ENTRIES)
    ) u_direction (
        .clk        (clk),
        .rst        (rst),
        .pc_i       (if_pc_i),
        .upd_i      (ex_upd_i),
        .taken_o    (dir_taken),
        .provider_o (provider),
        .history_o  (history)
    );

    bpu_btb #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (if_pc_i),
        .upd_i    (ex_upd_i),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    bpu_ras #(
        .RAS_DEPTH (RAS_DEPTH)
    ) u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (id_push_i),
        .push_addr_i (id_push_addr_i),
        .stall_i     (ex_stall_i),
        .upd_i       (ex_upd_i),
        .top_o       (ras_top),
        .valid_o     (ras_valid)
    );

    bpu_result u_result (
        .pc_i         (if_pc_i),
        .class_i      (inst_class),
        .dir_taken_i  (dir_taken),
        .provider_i   (provider),
        .history_i    (history),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .ras_top_i    (ras_top),
        .ras_valid_i  (ras_valid),
        .pred_o       (pred_o)
    );

endmodule

`default_nettype wire

// ==== verilog.f ====
source/bpu_pkg.sv
source/bpu_decode.sv
source/bpu_direction.sv
source/bpu_btb.sv
source/bpu_ras.sv
source/bpu_result.sv
source/bpu_top.sv
bench/bpu_tb.sv
